// File: common/vslide_params.svh
`ifndef VSLIDE_PARAMS_SVH
`define VSLIDE_PARAMS_SVH

`default_nettype none

`define VLEN      64    // vector register width in bits
`define NUM_VREGS 32    // architectural vector registers
`define VL_WIDTH  7     // holds vl up to 64 elements

`default_nettype wire

`endif

// File: common/vslide_pkg.sv
`include "vslide_params.svh"
`default_nettype none

package vslide_pkg;

    typedef enum logic [1:0] {EW8, EW16, EW32, EW64} vsew_e;

    typedef enum logic [1:0] {LMUL_1, LMUL_2, LMUL_4, LMUL_8} vlmul_e;

    typedef enum logic {VSLIDE1UP, VSLIDE1DOWN} slide_op_e;

    typedef enum logic {IDLE, ISSUE} seq_state_e;

    typedef struct packed {
        slide_op_e   op;
        logic [4:0]  vd;
        logic [4:0]  vs2;
        logic [31:0] scalar;    // rs1 value
    } slide_cmd_t;

    typedef struct packed {
        slide_op_e            op;
        vsew_e                vsew;
        logic [`VL_WIDTH-1:0] elem_count;   // active elements in this register
        logic                 first;        // first register of the group
        logic                 last_chunk;   // last active element takes the scalar
        logic                 last;         // final register of the group
        logic [4:0]           vd;
    } slide_step_t;

    typedef struct packed {
        logic             we;
        logic [4:0]       addr;
        logic [`VLEN-1:0] data;
        logic             last;     // write closes the instruction
    } wb_t;

endpackage

`default_nettype wire

// File: rtl/vslide_decode.sv
`include "vslide_params.svh"
`default_nettype none

module vslide_decode (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   start,
    input  logic [31:0]            instr,
    input  logic [31:0]            scalar,
    input  vslide_pkg::vsew_e      vsew,
    input  vslide_pkg::vlmul_e     vlmul,
    input  logic                   busy,
    output logic                   cmd_valid,
    output vslide_pkg::slide_cmd_t cmd,
    output logic                   illegal
);
    import vslide_pkg::*;

    localparam logic [6:0] OPC_OP_V      = 7'b1010111;
    localparam logic [2:0] F3_OPMVX      = 3'b110;
    localparam logic [5:0] F6_SLIDE1UP   = 6'b001110;
    localparam logic [5:0] F6_SLIDE1DOWN = 6'b001111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [5:0] funct6;
    logic       vm;
    logic [4:0] vd;
    logic [4:0] vs2;
    logic [4:0] grp_mask;
    logic       enc_ok;
    logic       cfg_ok;
    logic       accept;

    assign opcode = instr[6:0];
    assign vd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign vs2    = instr[24:20];
    assign vm     = instr[25];        // 1 means unmasked
    assign funct6 = instr[31:26];

    assign grp_mask = 5'((6'd1 << vlmul) - 6'd1);   // low index bits that must be zero

    assign enc_ok = (opcode == OPC_OP_V) && (funct3 == F3_OPMVX) && vm &&
                    ((funct6 == F6_SLIDE1UP) || (funct6 == F6_SLIDE1DOWN));

    assign cfg_ok = (vsew != EW64) && ((vd & grp_mask) == 5'd0) &&
                    ((vs2 & grp_mask) == 5'd0);

    assign accept    = start & ~busy;     // start while busy is dropped
    assign cmd_valid = accept & enc_ok & cfg_ok;

    assign cmd = '{op: slide_op_e'(funct6[0]), vd: vd, vs2: vs2, scalar: scalar};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            illegal <= 1'b0;
        end else begin
            illegal <= accept & ~(enc_ok & cfg_ok);
        end
    end

endmodule

`default_nettype wire

// File: vslide_exec/vslide_sequencer.sv
`include "vslide_params.svh"
`default_nettype none

module vslide_sequencer (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    cmd_valid,
    input  vslide_pkg::slide_cmd_t  cmd,
    input  vslide_pkg::vsew_e       vsew,
    input  vslide_pkg::vlmul_e      vlmul,
    input  logic [`VL_WIDTH-1:0]    vl,
    output logic [4:0]              rd_addr_a,
    output logic [4:0]              rd_addr_b,
    output logic                    step_valid,
    output vslide_pkg::slide_step_t step,
    output logic [31:0]             scalar_q,
    output logic                    busy,
    input  logic                    done_in
);
    import vslide_pkg::*;

    seq_state_e           state;
    slide_cmd_t           cmd_q;
    logic [2:0]           idx;          // register within the group
    logic [2:0]           idx_last;
    logic [`VL_WIDTH-1:0] remaining;    // elements not yet covered
    logic [`VL_WIDTH-1:0] per_reg;
    logic [`VL_WIDTH-1:0] elem_count;
    logic                 last_reg;
    logic                 busy_q;

    // ************************************************************************
    // group geometry
    // ************************************************************************
    assign idx_last = 3'((4'd1 << vlmul) - 4'd1);

    always_comb begin
        case (vsew)
            EW8:     per_reg = `VL_WIDTH'(8);
            EW16:    per_reg = `VL_WIDTH'(4);
            default: per_reg = `VL_WIDTH'(2);
        endcase
    end

    assign elem_count = (remaining < per_reg) ? remaining : per_reg;
    assign last_reg   = (idx == idx_last);

    // ************************************************************************
    // issue FSM
    // ************************************************************************
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= IDLE;
            idx       <= 3'd0;
            remaining <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        state     <= ISSUE;
                        idx       <= 3'd0;
                        remaining <= vl;
                    end
                end
                ISSUE: begin
                    idx       <= idx + 3'd1;
                    remaining <= remaining - elem_count;
                    if (last_reg) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_valid) begin
            cmd_q <= cmd;
        end
    end

    // held from acceptance until the register file reports done
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q <= 1'b0;
        end else if (cmd_valid) begin
            busy_q <= 1'b1;
        end else if (done_in) begin
            busy_q <= 1'b0;
        end
    end

    assign busy = busy_q & ~done_in;

    // ************************************************************************
    // step outputs
    // ************************************************************************
    assign rd_addr_a  = cmd_q.vs2 + 5'(idx);    // source register
    assign rd_addr_b  = rd_addr_a + 5'd1;       // next register, for slide-down
    assign step_valid = (state == ISSUE);
    assign scalar_q   = cmd_q.scalar;

    assign step = '{
        op:         cmd_q.op,
        vsew:       vsew,
        elem_count: elem_count,
        first:      (idx == 3'd0),
        last_chunk: (remaining <= per_reg) || last_reg,
        last:       last_reg,
        vd:         cmd_q.vd + 5'(idx)
    };

endmodule

`default_nettype wire

// File: vslide_exec/vslide_unit.sv
`include "vslide_params.svh"
`default_nettype none

module vslide_unit (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    step_valid,
    input  vslide_pkg::slide_step_t step,
    input  logic [`VLEN-1:0]        first_operand,    // source register
    input  logic [`VLEN-1:0]        second_operand,   // next source register
    input  logic [31:0]             scalar,
    output vslide_pkg::wb_t         wb
);
    import vslide_pkg::*;

    localparam int NW = 3;      // 8, 16 and 32 bit elements

    logic [`VLEN-1:0] res_dn [NW];
    logic [`VLEN-1:0] res_up [NW];
    logic [31:0]      top_elem [NW];
    logic [1:0]       ew_sel;
    logic [31:0]      carry_q;    // top element of the previous register
    logic [`VLEN-1:0] result;

    logic             we_q;
    logic             last_q;
    logic [4:0]       addr_q;
    logic [`VLEN-1:0] data_q;

    // ************************************************************************
    // per-width slide paths
    // ************************************************************************
    for (genvar g = 0; g < NW; g++) begin : g_ew
        localparam int EW = 8 << g;
        localparam int NE = `VLEN / EW;

        logic [`VLEN-1:0] src_dn;
        logic [`VLEN-1:0] src_up;
        logic [`VLEN-1:0] dn;
        logic [`VLEN-1:0] up;

        assign src_dn = first_operand >> EW;    // element i holds source i+1
        assign src_up = first_operand << EW;    // element i holds source i-1

        always_comb begin
            for (int i = 0; i < NE; i++) begin
                if (i + 1 < step.elem_count) begin
                    dn[EW*i +: EW] = src_dn[EW*i +: EW];
                end else if (i + 1 == step.elem_count) begin
                    dn[EW*i +: EW] = step.last_chunk ? scalar[EW-1:0]
                                                     : second_operand[EW-1:0];
                end else begin
                    dn[EW*i +: EW] = first_operand[EW*i +: EW];   // tail
                end

                if (i >= step.elem_count) begin
                    up[EW*i +: EW] = first_operand[EW*i +: EW];   // tail
                end else if (i == 0) begin
                    up[EW*i +: EW] = step.first ? scalar[EW-1:0] : carry_q[EW-1:0];
                end else begin
                    up[EW*i +: EW] = src_up[EW*i +: EW];
                end
            end
        end

        assign res_dn[g]   = dn;
        assign res_up[g]   = up;
        assign top_elem[g] = 32'(first_operand[`VLEN-1 -: EW]);
    end

    assign ew_sel = (step.vsew == EW64) ? 2'd2 : step.vsew;

    assign result = (step.op == VSLIDE1DOWN) ? res_dn[ew_sel] : res_up[ew_sel];

    // carry for the next register of a slide-up
    always_ff @(posedge clk) begin
        if (step_valid) begin
            carry_q <= top_elem[ew_sel];
        end
    end

    // ************************************************************************
    // writeback register
    // ************************************************************************
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            we_q   <= 1'b0;
            last_q <= 1'b0;
        end else begin
            we_q   <= step_valid;
            last_q <= step_valid & step.last;
        end
    end

    always_ff @(posedge clk) begin
        if (step_valid) begin
            addr_q <= step.vd;
            data_q <= result;
        end
    end

    assign wb = '{we: we_q, addr: addr_q, data: data_q, last: last_q};

endmodule

`default_nettype wire

// File: rtl/vreg_file.sv
`include "vslide_params.svh"
`default_nettype none

module vreg_file (
    input  logic               clk,
    input  logic               reset_n,
    input  logic [4:0]         rd_addr_a,
    input  logic [4:0]         rd_addr_b,
    input  logic [4:0]         dbg_addr,
    output logic [`VLEN-1:0]   rd_data_a,
    output logic [`VLEN-1:0]   rd_data_b,
    output logic [`VLEN-1:0]   dbg_data,
    input  vslide_pkg::wb_t    wb,
    input  logic               load_en,
    input  logic [4:0]         load_addr,
    input  logic [`VLEN-1:0]   load_data,
    output logic               done
);
    logic [`VLEN-1:0] regs [`NUM_VREGS];

    always_ff @(posedge clk) begin
        if (wb.we) begin
            regs[wb.addr] <= wb.data;       // slide result wins over preload
        end else if (load_en) begin
            regs[load_addr] <= load_data;
        end
    end

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];
    assign dbg_data  = regs[dbg_addr];

    // one cycle after the last register is written
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            done <= 1'b0;
        end else begin
            done <= wb.we & wb.last;
        end
    end

endmodule

`default_nettype wire

// File: rtl/vslide_top.sv
`include "vslide_params.svh"
`default_nettype none

module vslide_top (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 start,
    input  logic [31:0]          instr,
    input  logic [31:0]          scalar,
    input  vslide_pkg::vsew_e    vsew,
    input  vslide_pkg::vlmul_e   vlmul,
    input  logic [`VL_WIDTH-1:0] vl,
    input  logic                 load_en,
    input  logic [4:0]           load_addr,
    input  logic [`VLEN-1:0]     load_data,
    input  logic [4:0]           dbg_addr,
    output logic                 busy,
    output logic                 done,
    output logic                 illegal,
    output logic [`VLEN-1:0]     dbg_data
);
    import vslide_pkg::*;

    logic             cmd_valid;
    slide_cmd_t       cmd;
    logic [4:0]       rd_addr_a;
    logic [4:0]       rd_addr_b;
    logic [`VLEN-1:0] rd_data_a;
    logic [`VLEN-1:0] rd_data_b;
    logic             step_valid;
    slide_step_t      step;
    logic [31:0]      scalar_q;
    wb_t              wb;

    vslide_decode u_decode (
        .clk       (clk),
        .reset_n   (reset_n),
        .start     (start),
        .instr     (instr),
        .scalar    (scalar),
        .vsew      (vsew),
        .vlmul     (vlmul),
        .busy      (busy),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .illegal   (illegal)
    );

    vslide_sequencer u_seq (
        .clk        (clk),
        .reset_n    (reset_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .vsew       (vsew),
        .vlmul      (vlmul),
        .vl         (vl),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .step_valid (step_valid),
        .step       (step),
        .scalar_q   (scalar_q),
        .busy       (busy),
        .done_in    (done)
    );

    vslide_unit u_unit (
        .clk            (clk),
        .reset_n        (reset_n),
        .step_valid     (step_valid),
        .step           (step),
        .first_operand  (rd_data_a),
        .second_operand (rd_data_b),
        .scalar         (scalar_q),
        .wb             (wb)
    );

    vreg_file u_vrf (
        .clk       (clk),
        .reset_n   (reset_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .dbg_addr  (dbg_addr),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .dbg_data  (dbg_data),
        .wb        (wb),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .done      (done)
    );

endmodule

`default_nettype wire

// File: tests/vslide_checker.sv
`default_nettype none

module vslide_checker (
    input logic               clk,
    input logic               reset_n,
    input logic               accept,     // decoded start, legal and not busy
    input vslide_pkg::vlmul_e vlmul,
    input logic               busy,
    input logic               done,
    input logic               illegal,
    input logic               we
);
    timeunit 1ns;
    timeprecision 1ps;
    import vslide_pkg::*;

    // ************************************************************************
    // pulse and write-enable rules
    // ************************************************************************
    a_done_illegal: assert property (@(posedge clk) disable iff (!reset_n)
        !(done && illegal))
        else $error("done and illegal are high in the same cycle");

    a_we_busy: assert property (@(posedge clk) disable iff (!reset_n)
        we |-> busy)
        else $error("register write while busy is low");

    a_reset_busy: assert property (@(posedge clk)
        !reset_n |=> !busy)
        else $error("busy is high one cycle after reset");

    // ************************************************************************
    // done latency is L+2 cycles after an accepted start
    // ************************************************************************
    a_lat_1: assert property (@(posedge clk) disable iff (!reset_n)
        (accept && vlmul == LMUL_1) |-> ##3 done)
        else $error("done late or missing for a single register group");

    a_lat_2: assert property (@(posedge clk) disable iff (!reset_n)
        (accept && vlmul == LMUL_2) |-> ##4 done)
        else $error("done late or missing for a two register group");

    a_lat_4: assert property (@(posedge clk) disable iff (!reset_n)
        (accept && vlmul == LMUL_4) |-> ##6 done)
        else $error("done late or missing for a four register group");

    a_lat_8: assert property (@(posedge clk) disable iff (!reset_n)
        (accept && vlmul == LMUL_8) |-> ##10 done)
        else $error("done late or missing for an eight register group");

endmodule

bind vslide_top vslide_checker u_checker (
    .clk     (clk),
    .reset_n (reset_n),
    .accept  (cmd_valid),
    .vlmul   (vlmul),
    .busy    (busy),
    .done    (done),
    .illegal (illegal),
    .we      (wb.we)
);

`default_nettype wire

// File: tests/tb_vslide.sv
`include "vslide_params.svh"
`default_nettype none

module tb_vslide;
    timeunit 1ns;
    timeprecision 1ps;
    import vslide_pkg::*;

    localparam int DONE_LIMIT = 40;     // cycles before a wait gives up

    logic                 clk;
    logic                 reset_n;
    logic                 start;
    logic [31:0]          instr;
    logic [31:0]          scalar;
    vsew_e                vsew;
    vlmul_e               vlmul;
    logic [`VL_WIDTH-1:0] vl;
    logic                 load_en;
    logic [4:0]           load_addr;
    logic [`VLEN-1:0]     load_data;
    logic [4:0]           dbg_addr;
    logic                 busy;
    logic                 done;
    logic                 illegal;
    logic [`VLEN-1:0]     dbg_data;

    logic [`VLEN-1:0] model_regs [`NUM_VREGS];    // expected register file
    int               errors;
    int               checks;
    int               tests_run;
    int               test_errs;
    string            test_name;

    vslide_top DUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .start     (start),
        .instr     (instr),
        .scalar    (scalar),
        .vsew      (vsew),
        .vlmul     (vlmul),
        .vl        (vl),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .dbg_addr  (dbg_addr),
        .busy      (busy),
        .done      (done),
        .illegal   (illegal),
        .dbg_data  (dbg_data)
    );

    always #2 clk = ~clk;

    // ************************************************************************
    // reference model and helpers
    // ************************************************************************
    function automatic logic [63:0] fill_word(input logic [4:0] a);
        return {8{a, 3'b110}};
    endfunction

    function automatic logic [31:0] encode_slide(input bit down, input int vd, input int vs2,
                                                 input logic [2:0] f3, input bit vm);
        return {5'b00111, down, vm, 5'(vs2), 5'd0, f3, 5'(vd), 7'b1010111};
    endfunction

    // group as one flat vector with register k at bits 64k and up
    function automatic logic [511:0] slide_model(input logic [511:0] src, input bit down,
                                                 input int ew, input int n, input logic [31:0] sc);
        logic [511:0] dst;
        logic [31:0]  mask;
        logic [31:0]  e;
        int           i;
        mask = (ew == 32) ? 32'hffff_ffff : ((32'd1 << ew) - 32'd1);
        dst  = src;                                     // tail keeps source
        for (i = 0; i < n; i++) begin
            if (down) begin
                e = (i == n - 1) ? sc : 32'(src >> (ew * (i + 1)));
            end else begin
                e = (i == 0) ? sc : 32'(src >> (ew * (i - 1)));
            end
            e   = e & mask;
            dst = dst & ~(512'(mask) << (ew * i));
            dst = dst | (512'(e) << (ew * i));
        end
        return dst;
    endfunction

    task automatic check_word(input string what, input logic [63:0] exp, input logic [63:0] got);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, got);
            errors++;
            test_errs++;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout in %s: the DUT never raised %s", test_name, what);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic report_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("%s: passed", test_name);
        end else begin
            $display("%s: %0d errors", test_name, test_errs);
        end
    endtask

    task automatic load_reg(input int addr, input logic [63:0] data);
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = 5'(addr);
        load_data = data;
        @(negedge clk);
        load_en = 1'b0;
        model_regs[addr] = data;
    endtask

    task automatic read_reg(input int addr, output logic [63:0] data);
        @(negedge clk);
        dbg_addr = 5'(addr);
        #1;                                 // async read settles
        data = dbg_data;
    endtask

    task automatic compare_all();
        logic [63:0] got;
        int          a;
        for (a = 0; a < `NUM_VREGS; a++) begin
            read_reg(a, got);
            check_word($sformatf("v%0d", a), model_regs[a], got);
        end
    endtask

    task automatic run_slide(input bit down, input int vd, input int vs2, input vsew_e sew,
                             input vlmul_e lmul, input int n, input logic [31:0] sc);
        int           grp;
        int           ew;
        int           k;
        int           cycles;
        logic [511:0] src;
        logic [511:0] dst;
        grp = 1 << int'(lmul);
        ew  = 8 << int'(sew);
        src = '0;
        for (k = 0; k < grp; k++) begin
            src[64*k +: 64] = model_regs[vs2 + k];
        end
        dst = slide_model(src, down, ew, n, sc);
        @(negedge clk);
        vsew   = sew;
        vlmul  = lmul;
        vl     = `VL_WIDTH'(n);
        instr  = encode_slide(down, vd, vs2, 3'b110, 1'b1);
        scalar = sc;
        start  = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        cycles = 1;
        while (done !== 1'b1 && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            abort_on_timeout("done");
        end else begin
            check_word("done latency", 64'(grp + 2), 64'(cycles));
            for (k = 0; k < grp; k++) begin
                model_regs[vd + k] = dst[64*k +: 64];
            end
            compare_all();
        end
    endtask

    task automatic run_illegal(input string what, input logic [31:0] bad, input vsew_e sew,
                               input vlmul_e lmul, input int vd);
        int          cycles;
        int          seen_done;
        int          seen_busy;
        logic [63:0] got;
        @(negedge clk);
        vsew   = sew;
        vlmul  = lmul;
        vl     = `VL_WIDTH'(4);
        instr  = bad;
        scalar = 32'hdead_0001;
        start  = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        cycles = 1;
        while (illegal !== 1'b1 && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (illegal !== 1'b1) begin
            abort_on_timeout("illegal");
        end else begin
            seen_done = 0;
            seen_busy = 0;
            repeat (12) begin                   // window longer than any group
                @(negedge clk);
                if (done === 1'b1) begin
                    seen_done++;
                end
                if (busy === 1'b1) begin
                    seen_busy++;
                end
            end
            check_word({what, " done pulses"}, 64'd0, 64'(seen_done));
            check_word({what, " busy cycles"}, 64'd0, 64'(seen_busy));
            read_reg(vd, got);
            check_word({what, " vd"}, model_regs[vd], got);
        end
    endtask

    // ************************************************************************
    // directed tests
    // ************************************************************************
    task automatic test_down_ew32();
        logic [63:0] got;
        begin_test("test_down_ew32");
        load_reg(4, 64'hbbbb_0002_aaaa_0001);
        run_slide(1'b1, 8, 4, EW32, LMUL_1, 2, 32'h5ca1_ab1e);
        read_reg(8, got);
        check_word("v8 slid", 64'h5ca1_ab1e_bbbb_0002, got);
        report_test();
    endtask

    task automatic test_up_ew8_group();
        logic [63:0] got;
        begin_test("test_up_ew8_group");
        load_reg(16, 64'h8877_6655_4433_2211);
        load_reg(17, 64'hffee_ddcc_bbaa_9900);
        run_slide(1'b0, 18, 16, EW8, LMUL_2, 16, 32'h0000_00a5);
        read_reg(18, got);
        check_word("v18 slid", 64'h7766_5544_3322_11a5, got);
        read_reg(19, got);
        check_word("v19 carry", 64'heedd_ccbb_aa99_0088, got);     // top byte of v16
        report_test();
    endtask

    task automatic test_down_ew16_tail();
        logic [63:0] got;
        begin_test("test_down_ew16_tail");
        load_reg(8, 64'h0004_0003_0002_0001);
        load_reg(9, 64'h0008_0007_0006_0005);
        run_slide(1'b1, 12, 8, EW16, LMUL_4, 6, 32'h0000_beef);
        read_reg(13, got);
        check_word("v13 scalar", 64'h0008_0007_beef_0006, got);
        read_reg(14, got);
        check_word("v14 tail", fill_word(5'd10), got);
        report_test();
    endtask

    task automatic test_illegal();
        begin_test("test_illegal");
        run_illegal("funct3", encode_slide(1'b1, 20, 4, 3'b000, 1'b1), EW32, LMUL_1, 20);
        run_illegal("vm", encode_slide(1'b0, 20, 4, 3'b110, 1'b0), EW32, LMUL_1, 20);
        run_illegal("misaligned", encode_slide(1'b1, 21, 4, 3'b110, 1'b1), EW16, LMUL_2, 21);
        run_illegal("ew64", encode_slide(1'b0, 20, 4, 3'b110, 1'b1), EW64, LMUL_1, 20);
        report_test();
    endtask

    task automatic test_random();
        vsew_e  sew;
        vlmul_e lmul;
        int     grp;
        int     ngrp;
        int     vlmax;
        int     g_src;
        int     g_dst;
        int     k;
        begin_test("test_random");
        repeat (20) begin
            sew   = vsew_e'(2'($urandom_range(2, 0)));
            lmul  = vlmul_e'(2'($urandom_range(3, 0)));
            grp   = 1 << int'(lmul);
            ngrp  = 32 / grp;
            vlmax = grp * 64 / (8 << int'(sew));
            g_src = int'($urandom_range(ngrp - 1, 0));
            g_dst = (g_src + int'($urandom_range(ngrp - 1, 1))) % ngrp;   // never overlaps
            for (k = 0; k < grp; k++) begin
                load_reg(g_src * grp + k, {$urandom, $urandom});
                load_reg(g_dst * grp + k, {$urandom, $urandom});
            end
            run_slide(1'($urandom_range(1, 0)), g_dst * grp, g_src * grp, sew, lmul,
                      int'($urandom_range(vlmax, 1)), $urandom);
        end
        report_test();
    endtask

    initial begin
        clk       = 1'b0;
        reset_n   = 1'b0;
        start     = 1'b0;
        instr     = '0;
        scalar    = '0;
        vsew      = EW8;
        vlmul     = LMUL_1;
        vl        = '0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        dbg_addr  = '0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        test_errs = 0;
        void'($urandom(66));
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        for (int a = 0; a < `NUM_VREGS; a++) begin
            load_reg(a, fill_word(5'(a)));
        end

        test_down_ew32();
        test_up_ew8_group();
        test_down_ew16_tail();
        test_illegal();
        test_random();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/vslide_pkg.sv
rtl/vslide_decode.sv
vslide_exec/vslide_sequencer.sv
vslide_exec/vslide_unit.sv
rtl/vreg_file.sv
rtl/vslide_top.sv
tests/vslide_checker.sv
tests/tb_vslide.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_vslide
FILELIST = tb.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)
